//--- Makefile
# Verilator flow for the APB GPIO and display peripheral.

TOP := tb_gpio_apb

.PHONY: all lint sim clean

all: sim

# Lint the design top and the testbench top.
lint:
	verilator --lint-only --timing -f filelist.f --top-module gpio_apb_top
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

# Build and run; the result is taken from the pass line in the output.
sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "sim passed"

clean:
	rm -rf obj_dir

//--- dv/tb_gpio_apb.sv
module tb_gpio_apb;

    localparam int GPIO_WIDTH    = 16;
    localparam int SYNC_STAGES   = 2;
    localparam int READY_TIMEOUT = 8;

    logic                            clock;
    logic                            reset;
    logic [31:0]                     paddr;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [gpio_pkg::APB_DATA_W-1:0] pwdata;
    logic [gpio_pkg::APB_STRB_W-1:0] pstrb;
    logic                            pready;
    logic [gpio_pkg::APB_DATA_W-1:0] prdata;
    logic                            pslverr;
    logic [GPIO_WIDTH-1:0]           gpio_in;
    logic [GPIO_WIDTH-1:0]           gpio_out;
    logic [7:0]                      seg_out [gpio_pkg::SEG_DIGITS];

    // Reference models of the three registers.
    logic [31:0]                     out_model;
    logic [GPIO_WIDTH-1:0]           in_model;
    logic [31:0]                     seg_model;
    logic [gpio_pkg::SEG_DIGITS-1:0] lit_model;
    integer                          seed;

    gpio_apb_top #(
        .GPIO_WIDTH  (GPIO_WIDTH),
        .SYNC_STAGES (SYNC_STAGES)
    ) i_dut (
        .clock   (clock),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr),
        .gpio_in (gpio_in),
        .gpio_out(gpio_out),
        .seg_0   (seg_out[0]),
        .seg_1   (seg_out[1]),
        .seg_2   (seg_out[2]),
        .seg_3   (seg_out[3]),
        .seg_4   (seg_out[4]),
        .seg_5   (seg_out[5]),
        .seg_6   (seg_out[6]),
        .seg_7   (seg_out[7])
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // ########################################
    // Reference functions
    // ########################################

    function automatic logic [7:0] glyph(input logic [3:0] value);
        logic [6:0] on;                               // Lit segments, a down to g.
        on = 7'b0;
        case (value)
            4'h0: on = 7'b1111110;
            4'h1: on = 7'b0110000;
            4'h2: on = 7'b1101101;
            4'h3: on = 7'b1111001;
            4'h4: on = 7'b0110011;
            4'h5: on = 7'b1011011;
            4'h6: on = 7'b1011111;
            4'h7: on = 7'b1110000;
            4'h8: on = 7'b1111111;
            4'h9: on = 7'b1111011;
            4'ha: on = 7'b1110111;
            4'hb: on = 7'b0011111;
            4'hc: on = 7'b1001110;
            4'hd: on = 7'b0111101;
            4'he: on = 7'b1001111;
            4'hf: on = 7'b1000111;
        endcase
        return {~on, 1'b1};                           // Active low, dot dark.
    endfunction

    function automatic logic [31:0] reg_addr(input logic [1:0] idx);
        return {28'h0, idx, 2'b00};
    endfunction

    function automatic logic is_error(input logic [1:0] idx, input logic write);
        return (idx == 2'd3) || (write && idx == gpio_pkg::REG_IN);
    endfunction

    function automatic logic [31:0] expected_read(input logic [1:0] idx);
        logic [31:0] word;
        word = '0;
        if (idx == gpio_pkg::REG_OUT) word[GPIO_WIDTH-1:0] = out_model[GPIO_WIDTH-1:0];
        if (idx == gpio_pkg::REG_IN)  word[GPIO_WIDTH-1:0] = in_model;
        if (idx == gpio_pkg::REG_SEG) word = seg_model;
        return word;
    endfunction

    function automatic logic [7:0] expected_seg(input int d);
        return lit_model[d] ? glyph(seg_model[4*d +: 4]) : gpio_pkg::SEG_BLANK;
    endfunction

    // ########################################
    // Compare tasks
    // ########################################

    task automatic report_mismatch(input string what, input logic [31:0] got, exp);
        $display("Error at time %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        $display("sim failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic check_word(input logic [gpio_pkg::APB_DATA_W-1:0] got, exp,
                              input string what);
        if (got !== exp) report_mismatch(what, got, exp);
    endtask

    task automatic check_gpio(input logic [GPIO_WIDTH-1:0] got, exp, input string what);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic check_seg(input logic [7:0] got, exp, input string what);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic check_err(input logic got, exp, input string what);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    // ########################################
    // APB driver
    // ########################################

    task automatic apb_transfer(input logic [31:0] addr, input logic write,
                                input logic [31:0] data, input logic [3:0] strb,
                                output logic [31:0] rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge clock);
        paddr   <= addr;                              // Setup phase.
        pwrite  <= write;
        pwdata  <= data;
        pstrb   <= strb;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clock);
        penable <= 1'b1;                              // Access phase.
        @(negedge clock);
        while (!pready) begin
            waited++;
            if (waited > READY_TIMEOUT) begin
                $display("sim failed");
                $fatal(1, "pready did not rise within %0d cycles", READY_TIMEOUT);
            end
            @(negedge clock);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clock);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, data, input logic [3:0] strb,
                             output logic err);
        logic [31:0] unused;
        apb_transfer(addr, 1'b1, data, strb, unused, err);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata,
                            output logic err);
        apb_transfer(addr, 1'b0, 32'h0, 4'h0, rdata, err);
    endtask

    // ########################################
    // Checked accesses
    // ########################################

    task automatic check_pins();
        @(negedge clock);                             // One cycle after the access.
        check_err(pready, 1'b0, "pready while idle");
        check_err(pslverr, 1'b0, "pslverr while idle");
        check_gpio(gpio_out, out_model[GPIO_WIDTH-1:0], "gpio_out");
        for (int d = 0; d < gpio_pkg::SEG_DIGITS; d++) begin
            check_seg(seg_out[d], expected_seg(d), $sformatf("seg_%0d", d));
        end
    endtask

    task automatic write_and_track(input logic [31:0] addr, data, input logic [3:0] strb);
        logic err;
        logic [1:0] idx;
        idx = addr[3:2];
        apb_write(addr, data, strb, err);
        check_err(err, is_error(idx, 1'b1), "pslverr on write");
        for (int b = 0; b < 4; b++) begin
            if (strb[b] && !is_error(idx, 1'b1)) begin
                if (idx == gpio_pkg::REG_OUT) out_model[8*b +: 8] = data[8*b +: 8];
                if (idx == gpio_pkg::REG_SEG) begin
                    seg_model[8*b +: 8]  = data[8*b +: 8];
                    lit_model[2*b +: 2] = 2'b11;
                end
            end
        end
        check_pins();
    endtask

    task automatic read_and_compare(input logic [31:0] addr);
        logic [31:0] rdata;
        logic err;
        apb_read(addr, rdata, err);
        check_err(err, is_error(addr[3:2], 1'b0), "pslverr on read");
        if (!is_error(addr[3:2], 1'b0)) check_word(rdata, expected_read(addr[3:2]), "prdata");
    endtask

    task automatic drive_input(input logic [GPIO_WIDTH-1:0] value);
        logic [31:0] rdata;
        logic err;
        int tries;
        tries = 0;
        @(posedge clock);
        gpio_in <= value;
        in_model = value;
        apb_read(reg_addr(gpio_pkg::REG_IN), rdata, err);
        while (rdata !== expected_read(gpio_pkg::REG_IN)) begin   // Upper bits must be zero.
            tries++;
            if (tries > SYNC_STAGES + 3) begin
                $display("sim failed");
                $fatal(1, "input register never showed the driven pin value");
            end
            apb_read(reg_addr(gpio_pkg::REG_IN), rdata, err);
        end
        check_err(err, 1'b0, "pslverr on input read");
    endtask

    task automatic read_all_registers();
        read_and_compare(reg_addr(gpio_pkg::REG_OUT));
        read_and_compare(reg_addr(gpio_pkg::REG_IN));
        read_and_compare(reg_addr(gpio_pkg::REG_SEG));
    endtask

    // ########################################
    // Tests
    // ########################################

    task automatic reset_values();
        check_pins();
        read_all_registers();
    endtask

    task automatic output_strobes();
        write_and_track(reg_addr(gpio_pkg::REG_OUT), 32'h0000_a5c3, 4'b0011);
        write_and_track(reg_addr(gpio_pkg::REG_OUT), 32'h0000_ff00, 4'b0010);
        write_and_track(reg_addr(gpio_pkg::REG_OUT), 32'h1234_0077, 4'b0001);
        write_and_track(reg_addr(gpio_pkg::REG_OUT), 32'hdead_beef, 4'b1100);
        write_and_track(reg_addr(gpio_pkg::REG_OUT), 32'h0000_0000, 4'b0000);
        read_and_compare(reg_addr(gpio_pkg::REG_OUT));
    endtask

    task automatic input_sampling();
        drive_input(16'hbeef);
        drive_input(16'h0001);
        drive_input(16'h8000);
    endtask

    task automatic display_digits();
        write_and_track(reg_addr(gpio_pkg::REG_SEG), 32'h8765_4321, 4'b0001);
        write_and_track(reg_addr(gpio_pkg::REG_SEG), 32'hfedc_ba98, 4'b0100);
        write_and_track(reg_addr(gpio_pkg::REG_SEG), 32'h0b0d_c0e0, 4'b1010);
        read_and_compare(reg_addr(gpio_pkg::REG_SEG));
        write_and_track(reg_addr(gpio_pkg::REG_SEG), 32'h1234_5678, 4'b1111);
        read_and_compare(reg_addr(gpio_pkg::REG_SEG));
    endtask

    task automatic error_responses();
        write_and_track(32'h0000_000c, 32'hffff_ffff, 4'b1111);
        read_and_compare(32'h0000_000c);
        write_and_track(reg_addr(gpio_pkg::REG_IN), 32'h0000_5555, 4'b1111);
        read_all_registers();
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] addr;
        for (int n = 0; n < 48; n++) begin
            r    = $random(seed);
            data = $random(seed);
            addr = {r[31:4], r[1:0], 2'b00};          // Upper bits alias the map.
            if (r[7:5] == 3'd0) drive_input(data[GPIO_WIDTH-1:0]);
            if (r[2]) write_and_track(addr, data, r[11:8]);
            else read_and_compare(addr);
        end
        read_all_registers();
    endtask

    initial begin
        seed      = 80;
        reset     = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        pstrb     = '0;
        gpio_in   = '0;
        out_model = '0;
        in_model  = '0;
        seg_model = '0;
        lit_model = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        reset_values();
        output_strobes();
        input_sampling();
        display_digits();
        error_responses();
        random_traffic();
        $display("sim passed");
        $finish;
    end

endmodule

//--- filelist.f
verilog/gpio_pkg.sv
verilog/apb_reg_decode.sv
verilog/gpio_port.sv
verilog/seg_digit_bank.sv
verilog/seg7_decode.sv
verilog/gpio_apb_top.sv
dv/tb_gpio_apb.sv

//--- verilog/apb_reg_decode.sv
module apb_reg_decode #(
    parameter int GPIO_WIDTH = 16
) (
    input  logic                            clock,
    input  logic                            reset,

    input  logic [31:0]                     paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    output logic                            pready,
    output logic [gpio_pkg::APB_DATA_W-1:0] prdata,
    output logic                            pslverr,

    input  logic [GPIO_WIDTH-1:0]           out_value,
    input  logic [GPIO_WIDTH-1:0]           in_value,
    input  logic [gpio_pkg::APB_DATA_W-1:0] digit_value,

    output logic                            write_out,
    output logic                            write_seg
);

    logic [1:0] reg_idx;
    logic       access;
    logic       mapped;
    logic       bad_write;

    // ########################################
    // Access phase decode
    // ########################################

    assign reg_idx = paddr[3:2];                      // Upper address bits are ignored.
    assign access  = psel & penable;
    assign pready  = access;                          // Zero wait states.

    assign mapped    = (reg_idx == gpio_pkg::REG_OUT) ||
                       (reg_idx == gpio_pkg::REG_IN)  ||
                       (reg_idx == gpio_pkg::REG_SEG);
    assign bad_write = pwrite && (reg_idx == gpio_pkg::REG_IN);

    assign pslverr = access & (~mapped | bad_write);

    assign write_out = access & pwrite & (reg_idx == gpio_pkg::REG_OUT);
    assign write_seg = access & pwrite & (reg_idx == gpio_pkg::REG_SEG);

    // ########################################
    // Read data mux
    // ########################################

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (reg_idx)
                gpio_pkg::REG_OUT: prdata[GPIO_WIDTH-1:0] = out_value;
                gpio_pkg::REG_IN:  prdata[GPIO_WIDTH-1:0] = in_value;
                gpio_pkg::REG_SEG: prdata = digit_value;
                default:           prdata = '0;
            endcase
        end
    end

    // ########################################
    // Protocol checks
    // ########################################

    // Every access phase follows a setup cycle of the same transfer.
    a_pready_after_setup: assert property (
        @(posedge clock) disable iff (reset)
        pready |-> psel && $past(psel && !penable)
    ) else $error("pready without a preceding APB setup cycle");

    // Write pulses are exclusive and last one cycle only.
    a_write_pulse: assert property (
        @(posedge clock) disable iff (reset)
        (write_out || write_seg) |-> !(write_out && write_seg) ##1 !(write_out || write_seg)
    ) else $error("register write pulses overlap or stretch");

endmodule

//--- verilog/gpio_apb_top.sv
module gpio_apb_top #(
    parameter int GPIO_WIDTH  = 16,
    parameter int SYNC_STAGES = 2
) (
    input  logic                            clock,
    input  logic                            reset,

    input  logic [31:0]                     paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [gpio_pkg::APB_DATA_W-1:0] pwdata,
    input  logic [gpio_pkg::APB_STRB_W-1:0] pstrb,
    output logic                            pready,
    output logic [gpio_pkg::APB_DATA_W-1:0] prdata,
    output logic                            pslverr,

    input  logic [GPIO_WIDTH-1:0]           gpio_in,
    output logic [GPIO_WIDTH-1:0]           gpio_out,

    output logic [7:0]                      seg_0,
    output logic [7:0]                      seg_1,
    output logic [7:0]                      seg_2,
    output logic [7:0]                      seg_3,
    output logic [7:0]                      seg_4,
    output logic [7:0]                      seg_5,
    output logic [7:0]                      seg_6,
    output logic [7:0]                      seg_7
);

    logic                            write_out;
    logic                            write_seg;
    logic [GPIO_WIDTH-1:0]           out_value;
    logic [GPIO_WIDTH-1:0]           in_value;
    logic [gpio_pkg::APB_DATA_W-1:0] digit_value;
    logic [gpio_pkg::SEG_DIGITS-1:0] digit_lit;
    logic [7:0]                      seg_pattern [gpio_pkg::SEG_DIGITS];

    apb_reg_decode #(
        .GPIO_WIDTH  (GPIO_WIDTH)
    ) i_decode (
        .clock       (clock),
        .reset       (reset),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pready      (pready),
        .prdata      (prdata),
        .pslverr     (pslverr),
        .out_value   (out_value),
        .in_value    (in_value),
        .digit_value (digit_value),
        .write_out   (write_out),
        .write_seg   (write_seg)
    );

    gpio_port #(
        .GPIO_WIDTH  (GPIO_WIDTH),
        .SYNC_STAGES (SYNC_STAGES)
    ) i_port (
        .clock       (clock),
        .reset       (reset),
        .write_out   (write_out),
        .pwdata      (pwdata),
        .pstrb       (pstrb),
        .gpio_in     (gpio_in),
        .gpio_out    (gpio_out),
        .out_value   (out_value),
        .in_value    (in_value)
    );

    seg_digit_bank i_digits (
        .clock       (clock),
        .reset       (reset),
        .write_seg   (write_seg),
        .pwdata      (pwdata),
        .pstrb       (pstrb),
        .digit_value (digit_value),
        .digit_lit   (digit_lit)
    );

    // One glyph decoder per digit.
    for (genvar d = 0; d < gpio_pkg::SEG_DIGITS; d++) begin : g_glyph
        seg7_decode i_glyph (
            .nibble (digit_value[4*d +: 4]),
            .lit    (digit_lit[d]),
            .seg    (seg_pattern[d])
        );
    end

    assign seg_0 = seg_pattern[0];                    // Rightmost digit.
    assign seg_1 = seg_pattern[1];
    assign seg_2 = seg_pattern[2];
    assign seg_3 = seg_pattern[3];
    assign seg_4 = seg_pattern[4];
    assign seg_5 = seg_pattern[5];
    assign seg_6 = seg_pattern[6];
    assign seg_7 = seg_pattern[7];

endmodule

//--- verilog/gpio_pkg.sv
package gpio_pkg;

    // ########################################
    // APB bus geometry
    // ########################################

    localparam int APB_DATA_W = 32;                 // Data bus width.
    localparam int APB_STRB_W = APB_DATA_W / 8;     // One strobe per byte.

    // ########################################
    // Register map, word index is paddr[3:2]
    // ########################################

    localparam logic [1:0] REG_OUT = 2'd0;          // Offset 0x0, output port.
    localparam logic [1:0] REG_IN  = 2'd1;          // Offset 0x4, input port, read only.
    localparam logic [1:0] REG_SEG = 2'd2;          // Offset 0x8, display digits.

    // Index 3 (offset 0xC) is not mapped and answers with an error.

    // ########################################
    // Seven-segment display
    // ########################################

    // Two hex nibbles per data byte.
    localparam int SEG_DIGITS = APB_STRB_W * 2;

    localparam logic [7:0] SEG_BLANK = 8'hff;       // Active low, all segments dark.

endpackage

//--- verilog/gpio_port.sv
module gpio_port #(
    parameter int GPIO_WIDTH  = 16,
    parameter int SYNC_STAGES = 2
) (
    input  logic                            clock,
    input  logic                            reset,

    input  logic                            write_out,
    input  logic [gpio_pkg::APB_DATA_W-1:0] pwdata,
    input  logic [gpio_pkg::APB_STRB_W-1:0] pstrb,

    input  logic [GPIO_WIDTH-1:0]           gpio_in,
    output logic [GPIO_WIDTH-1:0]           gpio_out,

    output logic [GPIO_WIDTH-1:0]           out_value,
    output logic [GPIO_WIDTH-1:0]           in_value
);

    logic [GPIO_WIDTH-1:0] sync_q [SYNC_STAGES];

    // ########################################
    // Output register
    // ########################################

    // Each bit follows the strobe of its own byte lane.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            gpio_out <= '0;
        end else if (write_out) begin
            for (int i = 0; i < GPIO_WIDTH; i++) begin
                if (pstrb[i / 8]) begin
                    gpio_out[i] <= pwdata[i];
                end
            end
        end
    end

    assign out_value = gpio_out;                      // Read back of the driven pins.

    // ########################################
    // Input synchronizer
    // ########################################

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < SYNC_STAGES; s++) begin
                sync_q[s] <= '0;
            end
        end else begin
            sync_q[0] <= gpio_in;                     // Metastable stage.
            for (int s = 1; s < SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
        end
    end

    assign in_value = sync_q[SYNC_STAGES-1];

    // ########################################
    // Checks
    // ########################################

    // The pins move only on the edge that closes a write to the output register.
    a_out_on_write: assert property (
        @(posedge clock) disable iff (reset)
        !$stable(gpio_out) |-> $past(write_out)
    ) else $error("gpio_out changed without a register write");

endmodule

//--- verilog/seg7_decode.sv
module seg7_decode (
    input  logic [3:0] nibble,
    input  logic       lit,
    output logic [7:0] seg
);

    // Active low, segment a in bit 7 down to g in bit 1, dot in bit 0.
    always_comb begin
        if (!lit) begin
            seg = gpio_pkg::SEG_BLANK;
        end else begin
            case (nibble)
                4'h0:    seg = 8'h03;
                4'h1:    seg = 8'h9f;
                4'h2:    seg = 8'h25;
                4'h3:    seg = 8'h0d;
                4'h4:    seg = 8'h99;
                4'h5:    seg = 8'h49;
                4'h6:    seg = 8'h41;
                4'h7:    seg = 8'h1f;
                4'h8:    seg = 8'h01;
                4'h9:    seg = 8'h09;
                4'ha:    seg = 8'h11;
                4'hb:    seg = 8'hc1;                 // Lower case b.
                4'hc:    seg = 8'h63;
                4'hd:    seg = 8'h85;                 // Lower case d.
                4'he:    seg = 8'h61;
                4'hf:    seg = 8'h71;
                default: seg = gpio_pkg::SEG_BLANK;
            endcase
        end
    end

endmodule

//--- verilog/seg_digit_bank.sv
module seg_digit_bank (
    input  logic                            clock,
    input  logic                            reset,

    input  logic                            write_seg,
    input  logic [gpio_pkg::APB_DATA_W-1:0] pwdata,
    input  logic [gpio_pkg::APB_STRB_W-1:0] pstrb,

    output logic [gpio_pkg::APB_DATA_W-1:0] digit_value,
    output logic [gpio_pkg::SEG_DIGITS-1:0] digit_lit
);

    // Nibble d of the word belongs to digit d.
    logic [gpio_pkg::APB_DATA_W-1:0] nibble_q;
    logic [gpio_pkg::SEG_DIGITS-1:0] lit_q;

    // ########################################
    // Digit registers
    // ########################################

    // Byte k carries digits 2k and 2k+1.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            nibble_q <= '0;
            lit_q    <= '0;                           // All digits dark.
        end else if (write_seg) begin
            for (int d = 0; d < gpio_pkg::SEG_DIGITS; d++) begin
                if (pstrb[d / 2]) begin
                    nibble_q[4*d +: 4] <= pwdata[4*d +: 4];
                    lit_q[d]           <= 1'b1;
                end
            end
        end
    end

    assign digit_value = nibble_q;
    assign digit_lit   = lit_q;

    // ########################################
    // Checks
    // ########################################

    // A digit lights up only after a strobed write to its byte.
    for (genvar d = 0; d < gpio_pkg::SEG_DIGITS; d++) begin : g_lit_check
        a_lit_after_write: assert property (
            @(posedge clock) disable iff (reset)
            $rose(lit_q[d]) |-> $past(write_seg && pstrb[d / 2])
        ) else $error("digit %0d lit without a write", d);
    end

endmodule
